/* jesd_rx_regmap.f */
rtl/jesd_rx_pkg.sv
rtl/axi_lite_slave.sv
rtl/event_sync.sv
rtl/rx_common_regs.sv
rtl/rx_sysref_regs.sv
rtl/rx_lane_regs.sv
rtl/jesd_rx_regmap.sv
verification/jesd_rx_regmap_tb.sv

/* rtl/axi_lite_slave.sv */
`timescale 1ns/1ps

module axi_lite_slave import jesd_rx_pkg::*; (
  input  logic        s_axi_aclk,
  input  logic        rst_n,
  input  logic        s_axi_awvalid,
  input  logic [13:0] s_axi_awaddr,
  output logic        s_axi_awready,
  input  logic        s_axi_wvalid,
  input  reg_data_t   s_axi_wdata,
  output logic        s_axi_wready,
  output logic        s_axi_bvalid,
  output logic [1:0]  s_axi_bresp,
  input  logic        s_axi_bready,
  input  logic        s_axi_arvalid,
  input  logic [13:0] s_axi_araddr,
  output logic        s_axi_arready,
  output logic        s_axi_rvalid,
  output logic [1:0]  s_axi_rresp,
  output reg_data_t   s_axi_rdata,
  input  logic        s_axi_rready,
  output reg_wr_t     wr,
  output logic        rreq,
  output reg_addr_t   raddr,
  input  logic        wack,
  input  logic        rack,
  input  reg_data_t   rdata
);

  logic      wr_ready;
  logic      wr_pend;
  logic      wreq_q;
  reg_addr_t waddr_q;
  reg_data_t wdata_q;
  logic      rd_pend;
  logic      rd_go;

  assign s_axi_awready = wr_ready;
  assign s_axi_wready = wr_ready;   // Address and data are taken on the same edge.
  assign s_axi_bresp = 2'b00;
  assign s_axi_rresp = 2'b00;
  assign wr = '{wreq: wreq_q, waddr: waddr_q, wdata: wdata_q};

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ready <= 1'b0;
      wr_pend <= 1'b0;
      wreq_q <= 1'b0;
      s_axi_bvalid <= 1'b0;
    end else begin
      // Valids are held until ready, so a raised ready always completes the handshake.
      wreq_q <= wr_ready;
      if (wr_ready) begin
        wr_ready <= 1'b0;
      end else if (s_axi_awvalid && s_axi_wvalid && !wr_pend) begin
        wr_ready <= 1'b1;
        wr_pend <= 1'b1;
      end
      if (wack) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bvalid && s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
        wr_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      s_axi_arready <= 1'b0;
      rd_pend <= 1'b0;
      rd_go <= 1'b0;
      rreq <= 1'b0;
      s_axi_rvalid <= 1'b0;
    end else begin
      rd_go <= s_axi_arready;
      rreq <= rd_go;   // The blocks see a settled raddr with the strobe.
      if (s_axi_arready) begin
        s_axi_arready <= 1'b0;
      end else if (s_axi_arvalid && !rd_pend) begin
        s_axi_arready <= 1'b1;
        rd_pend <= 1'b1;
      end
      if (rack) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rvalid && s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
        rd_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (wr_ready) begin
      waddr_q <= s_axi_awaddr[13:2];
      wdata_q <= s_axi_wdata;
    end
    if (s_axi_arready) raddr <= s_axi_araddr[13:2];
    if (rack) s_axi_rdata <= rdata;
  end

endmodule

/* rtl/event_sync.sv */
`timescale 1ns/1ps

module event_sync import jesd_rx_pkg::*; (
  input  logic         core_clk,
  input  logic         s_axi_aclk,
  input  logic         rst_n,
  input  core_events_t events_in,
  output core_events_t events_out
);

  logic [num_events-1:0] tog_core;
  logic [num_events-1:0] sync1;
  logic [num_events-1:0] sync2;
  logic [num_events-1:0] sync3;
  logic [num_events-1:0] sync3_d;

  // A source pulse flips its toggle bit, so pulses must be spaced wider than the synchronizer.
  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) tog_core <= '0;
    else tog_core <= tog_core ^ events_in;
  end

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      sync1 <= '0;
      sync2 <= '0;
      sync3 <= '0;
      sync3_d <= '0;
    end else begin
      sync1 <= tog_core;
      sync2 <= sync1;
      sync3 <= sync2;
      sync3_d <= sync3;
    end
  end

  assign events_out = sync3 ^ sync3_d;   // Each toggle edge becomes one pulse.

endmodule

/* rtl/jesd_rx_pkg.sv */
package jesd_rx_pkg;

  localparam int num_lanes = 4;
  localparam int lane_idx_bits = $clog2(num_lanes);

  typedef logic [11:0] reg_addr_t;       // Word address taken from bits 13:2 of the AXI byte address.
  typedef logic [31:0] reg_data_t;
  typedef logic [num_lanes-1:0] lane_mask_t;
  typedef logic [7:0] octet_cnt_t;

  localparam reg_data_t core_version = 32'h00010761;
  localparam reg_data_t core_magic = 32'h32303452;   // ASCII "204R".

  localparam reg_addr_t addr_version = 12'h000;
  localparam reg_addr_t addr_scratch = 12'h002;
  localparam reg_addr_t addr_magic = 12'h003;
  localparam reg_addr_t addr_irq_enable = 12'h020;
  localparam reg_addr_t addr_irq_pending = 12'h021;
  localparam reg_addr_t addr_link_disable = 12'h030;
  localparam reg_addr_t addr_sysref_conf = 12'h040;
  localparam reg_addr_t addr_lmfc_offset = 12'h041;
  localparam reg_addr_t addr_sysref_status = 12'h042;
  localparam reg_addr_t addr_lanes_disable = 12'h080;
  localparam reg_addr_t addr_octets_per_frame = 12'h084;
  localparam reg_addr_t addr_octets_per_multiframe = 12'h085;
  localparam reg_addr_t addr_frame_align_threshold = 12'h090;
  localparam reg_addr_t addr_ctrl_state = 12'h0a0;
  localparam reg_addr_t addr_buffer_conf = 12'h0b0;

  // Each lane owns one window of lane_stride words starting at addr_lane_base.
  localparam reg_addr_t addr_lane_base = 12'h100;
  localparam reg_addr_t lane_stride = 12'h020;
  localparam int lane_word_bits = $clog2(lane_stride);
  localparam reg_addr_t addr_lane_end = addr_lane_base + reg_addr_t'(num_lanes * lane_stride);

  typedef struct packed {
    logic      wreq;
    reg_addr_t waddr;
    reg_data_t wdata;
  } reg_wr_t;

  typedef struct packed {
    lane_mask_t lanes_disable;
    octet_cnt_t octets_per_frame;        // Minus one.
    logic [9:0] octets_per_multiframe;   // Minus one.
    logic       disable_scrambler;
    octet_cnt_t frame_align_err_threshold;
  } link_cfg_t;

  typedef struct packed {
    logic       sysref_disable;
    logic       oneshot;
    octet_cnt_t lmfc_offset;
  } sysref_cfg_t;

  typedef struct packed {
    logic       early_release;
    octet_cnt_t delay;
  } buffer_cfg_t;

  typedef struct packed {
    logic [1:0]  cgs_state;
    logic [2:0]  emb_state;
    logic        ifs_ready;
    logic [13:0] latency;
    octet_cnt_t  frame_align_err_cnt;
  } lane_status_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] addr;
    reg_data_t  data;
  } ilas_wr_t;

  typedef struct packed {
    logic frame_align_err;
    logic lane_state_err;
    logic sysref_edge;
    logic sysref_align_err;
  } core_events_t;

  localparam int num_events = $bits(core_events_t);

endpackage

/* rtl/jesd_rx_regmap.sv */
`timescale 1ns/1ps

module jesd_rx_regmap import jesd_rx_pkg::*; (
  input  logic                         s_axi_aclk,
  input  logic                         rst_n,
  input  logic                         s_axi_awvalid,
  input  logic [13:0]                  s_axi_awaddr,
  output logic                         s_axi_awready,
  input  logic                         s_axi_wvalid,
  input  reg_data_t                    s_axi_wdata,
  output logic                         s_axi_wready,
  output logic                         s_axi_bvalid,
  output logic [1:0]                   s_axi_bresp,
  input  logic                         s_axi_bready,
  input  logic                         s_axi_arvalid,
  input  logic [13:0]                  s_axi_araddr,
  output logic                         s_axi_arready,
  output logic                         s_axi_rvalid,
  output logic [1:0]                   s_axi_rresp,
  output reg_data_t                    s_axi_rdata,
  input  logic                         s_axi_rready,
  input  logic                         core_clk,
  input  core_events_t                 core_events,
  input  logic [1:0]                   ctrl_state,
  input  lane_status_t [num_lanes-1:0] lane_status,
  input  ilas_wr_t [num_lanes-1:0]     ilas_lanes,
  output logic                         irq,
  output logic                         link_disable,
  output link_cfg_t                    link_cfg,
  output sysref_cfg_t                  sysref_cfg,
  output buffer_cfg_t                  buffer_cfg
);

  reg_wr_t      wr;
  logic         rreq;
  logic         rreq_d1;
  reg_addr_t    raddr;
  logic         wack;
  logic         rack;
  reg_data_t    rdata;
  reg_data_t    rdata_common;
  reg_data_t    rdata_sysref;
  reg_data_t    rdata_lane;
  core_events_t events;

  axi_lite_slave u_axi (
    .s_axi_aclk, .rst_n,
    .s_axi_awvalid, .s_axi_awaddr, .s_axi_awready,
    .s_axi_wvalid, .s_axi_wdata, .s_axi_wready,
    .s_axi_bvalid, .s_axi_bresp, .s_axi_bready,
    .s_axi_arvalid, .s_axi_araddr, .s_axi_arready,
    .s_axi_rvalid, .s_axi_rresp, .s_axi_rdata, .s_axi_rready,
    .wr, .rreq, .raddr, .wack, .rack, .rdata
  );

  event_sync u_event_sync (
    .core_clk, .s_axi_aclk, .rst_n,
    .events_in(core_events), .events_out(events)
  );

  rx_common_regs u_common (
    .s_axi_aclk, .rst_n, .wr, .raddr, .rdata(rdata_common),
    .events, .link_disable, .link_cfg, .irq
  );

  rx_sysref_regs u_sysref (
    .s_axi_aclk, .rst_n, .wr, .raddr, .rdata(rdata_sysref),
    .link_disable, .events, .sysref_cfg
  );

  rx_lane_regs u_lane (
    .s_axi_aclk, .rst_n, .wr, .rreq, .raddr, .rdata(rdata_lane),
    .link_disable, .ctrl_state, .lane_status, .ilas_lanes, .buffer_cfg
  );

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      wack <= 1'b0;
      rreq_d1 <= 1'b0;
      rack <= 1'b0;
    end else begin
      wack <= wr.wreq;
      rreq_d1 <= rreq;   // Extra cycle for the registered ILAS read.
      rack <= rreq_d1;
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (rreq_d1) rdata <= rdata_common | rdata_sysref | rdata_lane;
  end

endmodule

/* rtl/rx_common_regs.sv */
`timescale 1ns/1ps

module rx_common_regs import jesd_rx_pkg::*; (
  input  logic         s_axi_aclk,
  input  logic         rst_n,
  input  reg_wr_t      wr,
  input  reg_addr_t    raddr,
  output reg_data_t    rdata,
  input  core_events_t events,
  output logic         link_disable,
  output link_cfg_t    link_cfg,
  output logic         irq
);

  reg_data_t  scratch;
  logic [1:0] irq_enable;
  logic [1:0] irq_pending;
  logic [1:0] pend_set;
  logic [1:0] pend_clr;

  // Link errors only count as interrupts while the link is running.
  assign pend_set = {events.lane_state_err, events.frame_align_err} & {2{~link_disable}};
  assign pend_clr = (wr.wreq && wr.waddr == addr_irq_pending) ? wr.wdata[1:0] : 2'b00;

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      scratch <= '0;
      irq_enable <= 2'b00;
      irq_pending <= 2'b00;
      irq <= 1'b0;
      link_disable <= 1'b1;
      link_cfg <= '0;
    end else begin
      irq_pending <= (irq_pending & ~pend_clr) | pend_set;
      irq <= |(irq_pending & irq_enable);
      if (wr.wreq) begin
        case (wr.waddr)
          addr_scratch: scratch <= wr.wdata;
          addr_irq_enable: irq_enable <= wr.wdata[1:0];
          addr_link_disable: link_disable <= wr.wdata[0];
          default: ;
        endcase
        // The link configuration is frozen while the link is enabled.
        if (link_disable) begin
          case (wr.waddr)
            addr_lanes_disable: link_cfg.lanes_disable <= wr.wdata[num_lanes-1:0];
            addr_octets_per_frame: begin
              link_cfg.octets_per_frame <= wr.wdata[7:0];
              link_cfg.disable_scrambler <= wr.wdata[8];
            end
            addr_octets_per_multiframe: link_cfg.octets_per_multiframe <= wr.wdata[9:0];
            addr_frame_align_threshold: link_cfg.frame_align_err_threshold <= wr.wdata[7:0];
            default: ;
          endcase
        end
      end
    end
  end

  always_comb begin
    case (raddr)
      addr_version: rdata = core_version;
      addr_scratch: rdata = scratch;
      addr_magic: rdata = core_magic;
      addr_irq_enable: rdata = reg_data_t'(irq_enable);
      addr_irq_pending: rdata = reg_data_t'(irq_pending);
      addr_link_disable: rdata = reg_data_t'(link_disable);
      addr_lanes_disable: rdata = reg_data_t'(link_cfg.lanes_disable);
      addr_octets_per_frame:
        rdata = reg_data_t'({link_cfg.disable_scrambler, link_cfg.octets_per_frame});
      addr_octets_per_multiframe: rdata = reg_data_t'(link_cfg.octets_per_multiframe);
      addr_frame_align_threshold: rdata = reg_data_t'(link_cfg.frame_align_err_threshold);
      default: rdata = '0;
    endcase
  end

endmodule

/* rtl/rx_lane_regs.sv */
`timescale 1ns/1ps

module rx_lane_regs import jesd_rx_pkg::*; (
  input  logic                         s_axi_aclk,
  input  logic                         rst_n,
  input  reg_wr_t                      wr,
  input  logic                         rreq,
  input  reg_addr_t                    raddr,
  output reg_data_t                    rdata,
  input  logic                         link_disable,
  input  logic [1:0]                   ctrl_state,
  input  lane_status_t [num_lanes-1:0] lane_status,
  input  ilas_wr_t [num_lanes-1:0]     ilas_lanes,
  output buffer_cfg_t                  buffer_cfg
);

  reg_data_t                 ilas_mem [num_lanes][4];
  reg_data_t                 ilas_q;
  reg_data_t                 status_rdata;
  reg_addr_t                 lane_off;
  logic                      lane_hit;
  logic [lane_idx_bits-1:0]  lane_sel;
  logic [lane_word_bits-1:0] lane_word;
  lane_status_t              sel_status;

  assign lane_off = raddr - addr_lane_base;
  assign lane_hit = (raddr >= addr_lane_base) && (raddr < addr_lane_end);
  assign lane_sel = lane_off[lane_word_bits +: lane_idx_bits];
  assign lane_word = lane_off[lane_word_bits-1:0];
  assign sel_status = lane_status[lane_sel];

  // The core fills the ILAS words as they arrive on each lane.
  always_ff @(posedge s_axi_aclk) begin
    for (int l = 0; l < num_lanes; l++) begin
      if (ilas_lanes[l].valid) ilas_mem[l][ilas_lanes[l].addr] <= ilas_lanes[l].data;
    end
    if (rreq) begin
      if (lane_hit && lane_word[4:2] == 3'b100) ilas_q <= ilas_mem[lane_sel][lane_word[1:0]];
      else ilas_q <= '0;
    end
  end

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      buffer_cfg <= '0;
    end else if (wr.wreq && link_disable && wr.waddr == addr_buffer_conf) begin
      buffer_cfg.delay <= wr.wdata[7:0];
      buffer_cfg.early_release <= wr.wdata[16];
    end
  end

  always_comb begin
    status_rdata = '0;
    if (raddr == addr_ctrl_state) begin
      status_rdata = reg_data_t'(ctrl_state);
    end else if (raddr == addr_buffer_conf) begin
      status_rdata = {15'd0, buffer_cfg.early_release, 8'd0, buffer_cfg.delay};
    end else if (lane_hit) begin
      if (lane_word == 5'd0) begin
        status_rdata = {2'd0, sel_status.latency, 5'd0, sel_status.emb_state,
                        3'd0, sel_status.ifs_ready, 2'd0, sel_status.cgs_state};
      end else if (lane_word == 5'd2) begin
        status_rdata = reg_data_t'(sel_status.frame_align_err_cnt);
      end
    end
  end

  assign rdata = ilas_q | status_rdata;

endmodule

/* rtl/rx_sysref_regs.sv */
`timescale 1ns/1ps

module rx_sysref_regs import jesd_rx_pkg::*; (
  input  logic         s_axi_aclk,
  input  logic         rst_n,
  input  reg_wr_t      wr,
  input  reg_addr_t    raddr,
  output reg_data_t    rdata,
  input  logic         link_disable,
  input  core_events_t events,
  output sysref_cfg_t  sysref_cfg
);

  logic [1:0] status;
  logic [1:0] status_clr;

  assign status_clr = (wr.wreq && wr.waddr == addr_sysref_status) ? wr.wdata[1:0] : 2'b00;

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      status <= 2'b00;
      sysref_cfg <= '0;
    end else begin
      // Sticky until software writes a one.
      status <= (status & ~status_clr) | {events.sysref_align_err, events.sysref_edge};
      if (wr.wreq && link_disable) begin
        if (wr.waddr == addr_sysref_conf) begin
          sysref_cfg.sysref_disable <= wr.wdata[0];
          sysref_cfg.oneshot <= wr.wdata[1];
        end
        if (wr.waddr == addr_lmfc_offset) sysref_cfg.lmfc_offset <= wr.wdata[7:0];
      end
    end
  end

  always_comb begin
    case (raddr)
      addr_sysref_conf: rdata = reg_data_t'({sysref_cfg.oneshot, sysref_cfg.sysref_disable});
      addr_lmfc_offset: rdata = reg_data_t'(sysref_cfg.lmfc_offset);
      addr_sysref_status: rdata = reg_data_t'(status);
      default: rdata = '0;
    endcase
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the jesd_rx_regmap testbench with Verilator, runs it and judges the log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module jesd_rx_regmap_tb --Mdir "$build_dir" -o jesd_rx_regmap_sim \
  -f jesd_rx_regmap.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/jesd_rx_regmap_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
exit 0

/* verification/jesd_rx_regmap_tb.sv */
`timescale 1ns/1ps

module jesd_rx_regmap_tb import jesd_rx_pkg::*; ();

  localparam int wait_limit = 50;   // Clock cycles allowed for any single wait.
  localparam int poll_limit = 20;   // Register reads allowed while polling a status bit.
  localparam int rand_seed = 32'h2015e86e;

  localparam reg_addr_t zero_after_reset [14] = '{
    addr_scratch, addr_irq_enable, addr_irq_pending, addr_lanes_disable,
    addr_octets_per_frame, addr_octets_per_multiframe, addr_frame_align_threshold,
    addr_sysref_conf, addr_lmfc_offset, addr_sysref_status, addr_ctrl_state,
    addr_buffer_conf, addr_lane_base, addr_lane_base + 12'h002
  };
  localparam reg_addr_t config_regs [7] = '{
    addr_lanes_disable, addr_octets_per_frame, addr_octets_per_multiframe,
    addr_frame_align_threshold, addr_sysref_conf, addr_lmfc_offset, addr_buffer_conf
  };

  logic                         s_axi_aclk;
  logic                         rst_n;
  logic                         core_clk;
  logic                         s_axi_awvalid;
  logic [13:0]                  s_axi_awaddr;
  logic                         s_axi_awready;
  logic                         s_axi_wvalid;
  reg_data_t                    s_axi_wdata;
  logic                         s_axi_wready;
  logic                         s_axi_bvalid;
  logic [1:0]                   s_axi_bresp;
  logic                         s_axi_bready;
  logic                         s_axi_arvalid;
  logic [13:0]                  s_axi_araddr;
  logic                         s_axi_arready;
  logic                         s_axi_rvalid;
  logic [1:0]                   s_axi_rresp;
  reg_data_t                    s_axi_rdata;
  logic                         s_axi_rready;
  core_events_t                 core_events;
  logic [1:0]                   ctrl_state;
  lane_status_t [num_lanes-1:0] lane_status;
  ilas_wr_t [num_lanes-1:0]     ilas_lanes;
  logic                         irq;
  logic                         link_disable;
  link_cfg_t                    link_cfg;
  sysref_cfg_t                  sysref_cfg;
  buffer_cfg_t                  buffer_cfg;

  int   checks = 0;
  int   errors = 0;
  int   timeouts = 0;
  logic timed_out = 1'b0;
  int   seed_value;

  jesd_rx_regmap DUT (.*);

  initial begin
    s_axi_aclk = 1'b0;
    forever #20 s_axi_aclk = ~s_axi_aclk;
  end

  initial begin
    core_clk = 1'b0;
    forever #16 core_clk = ~core_clk;
  end

  task automatic check_word(input string what, input reg_data_t got, input reg_data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    timed_out = 1'b1;
    $display("Timeout at %0t ns: gave up waiting for %s", $time, what);
  endtask

  // Waits sample at the falling edge, so the handshake completes on the next rising edge.
  task automatic axi_write(input reg_addr_t addr, input reg_data_t data);
    int cycles;
    s_axi_awaddr = {addr, 2'b00};
    s_axi_wdata = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid = 1'b1;
    cycles = 0;
    do begin
      @(negedge s_axi_aclk);
      cycles++;
    end while (!(s_axi_awready && s_axi_wready) && cycles < wait_limit);
    if (!(s_axi_awready && s_axi_wready)) note_timeout("awready and wready");
    @(posedge s_axi_aclk);
    #2;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid = 1'b0;
    s_axi_bready = 1'b1;
    cycles = 0;
    do begin
      @(negedge s_axi_aclk);
      cycles++;
    end while (!s_axi_bvalid && cycles < wait_limit);
    if (!s_axi_bvalid) note_timeout("bvalid");
    check_word("write response", reg_data_t'(s_axi_bresp), '0);
    @(posedge s_axi_aclk);
    #2;
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input reg_addr_t addr, output reg_data_t data);
    int cycles;
    s_axi_araddr = {addr, 2'b00};
    s_axi_arvalid = 1'b1;
    cycles = 0;
    do begin
      @(negedge s_axi_aclk);
      cycles++;
    end while (!s_axi_arready && cycles < wait_limit);
    if (!s_axi_arready) note_timeout("arready");
    @(posedge s_axi_aclk);
    #2;
    s_axi_arvalid = 1'b0;
    s_axi_rready = 1'b1;
    cycles = 0;
    do begin
      @(negedge s_axi_aclk);
      cycles++;
    end while (!s_axi_rvalid && cycles < wait_limit);
    if (!s_axi_rvalid) note_timeout("rvalid");
    data = s_axi_rdata;
    check_word("read response", reg_data_t'(s_axi_rresp), '0);
    @(posedge s_axi_aclk);
    #2;
    s_axi_rready = 1'b0;
  endtask

  task automatic read_expect(input string what, input reg_addr_t addr, input reg_data_t exp);
    reg_data_t data;
    axi_read(addr, data);
    check_word(what, data, exp);
  endtask

  task automatic pulse_event(input core_events_t ev);
    @(posedge core_clk);
    #2;
    core_events = ev;
    @(posedge core_clk);
    #2;
    core_events = '0;
    @(posedge s_axi_aclk);
    #2;
  endtask

  task automatic wait_irq(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(negedge s_axi_aclk);
      cycles++;
    end while (irq !== level && cycles < wait_limit);
    if (irq !== level) note_timeout(level ? "irq to rise" : "irq to fall");
    @(posedge s_axi_aclk);
    #2;
  endtask

  task automatic wait_for_bits(input reg_addr_t addr, input reg_data_t mask, input string what);
    reg_data_t data;
    int reads;
    reads = 0;
    do begin
      axi_read(addr, data);
      reads++;
    end while ((data & mask) != mask && reads < poll_limit);
    if ((data & mask) != mask) note_timeout(what);
  endtask

  // Register word that holds a configuration field in the register map.
  function automatic reg_data_t cfg_word(input reg_addr_t addr, input link_cfg_t c,
                                         input sysref_cfg_t s, input buffer_cfg_t b);
    reg_data_t w;
    w = '0;
    case (addr)
      addr_lanes_disable: w[num_lanes-1:0] = c.lanes_disable;
      addr_octets_per_frame: w[8:0] = {c.disable_scrambler, c.octets_per_frame};
      addr_octets_per_multiframe: w[9:0] = c.octets_per_multiframe;
      addr_frame_align_threshold: w[7:0] = c.frame_align_err_threshold;
      addr_sysref_conf: w[1:0] = {s.oneshot, s.sysref_disable};
      addr_lmfc_offset: w[7:0] = s.lmfc_offset;
      addr_buffer_conf: begin
        w[16] = b.early_release;
        w[7:0] = b.delay;
      end
      default: ;
    endcase
    return w;
  endfunction

  function automatic reg_data_t lane_status_word(input lane_status_t s);
    reg_data_t w;
    w = '0;
    w[1:0] = s.cgs_state;
    w[4] = s.ifs_ready;
    w[10:8] = s.emb_state;
    w[29:16] = s.latency;
    return w;
  endfunction

  task automatic write_config(input link_cfg_t c, input sysref_cfg_t s, input buffer_cfg_t b);
    for (int i = 0; i < 7; i++) axi_write(config_regs[i], cfg_word(config_regs[i], c, s, b));
  endtask

  task automatic check_config(input link_cfg_t c, input sysref_cfg_t s, input buffer_cfg_t b);
    check_word("link_cfg output", reg_data_t'(link_cfg), reg_data_t'(c));
    check_word("sysref_cfg output", reg_data_t'(sysref_cfg), reg_data_t'(s));
    check_word("buffer_cfg output", reg_data_t'(buffer_cfg), reg_data_t'(b));
    for (int i = 0; i < 7; i++) begin
      read_expect($sformatf("config register %h", config_regs[i]), config_regs[i],
                  cfg_word(config_regs[i], c, s, b));
    end
  endtask

  task automatic check_reset_values();
    read_expect("version", addr_version, core_version);
    read_expect("magic", addr_magic, core_magic);
    read_expect("link_disable register", addr_link_disable, 32'h1);
    for (int i = 0; i < 14; i++) begin
      read_expect($sformatf("register %h after reset", zero_after_reset[i]),
                  zero_after_reset[i], '0);
    end
    check_word("irq after reset", reg_data_t'(irq), '0);
    check_word("link_disable output after reset", reg_data_t'(link_disable), 32'h1);
    check_config('0, '0, '0);
  endtask

  task automatic check_scratch();
    reg_data_t value;
    value = $urandom;
    axi_write(addr_scratch, value);
    read_expect("scratch", addr_scratch, value);
    axi_write(12'h7fe, 32'hffffffff);   // The address is unmapped and the write is dropped.
    read_expect("unmapped 7fe", 12'h7fe, '0);
    read_expect("unmapped 0a1", 12'h0a1, '0);
  endtask

  task automatic check_write_protect();
    link_cfg_t   first_link;
    sysref_cfg_t first_sysref;
    buffer_cfg_t first_buf;
    first_link = '{lanes_disable: 4'ha, octets_per_frame: 8'h03,
                   octets_per_multiframe: 10'h01f, disable_scrambler: 1'b1,
                   frame_align_err_threshold: 8'h20};
    first_sysref = '{sysref_disable: 1'b0, oneshot: 1'b1, lmfc_offset: 8'h11};
    first_buf = '{early_release: 1'b1, delay: 8'h40};
    write_config(first_link, first_sysref, first_buf);
    check_config(first_link, first_sysref, first_buf);
    axi_write(addr_link_disable, '0);
    check_word("link_disable output", reg_data_t'(link_disable), '0);
    read_expect("link_disable register", addr_link_disable, '0);
    // Every bit differs from the first set.
    write_config(~first_link, ~first_sysref, ~first_buf);
    check_config(first_link, first_sysref, first_buf);
  endtask

  task automatic check_interrupts();
    axi_write(addr_irq_enable, 32'h1);
    pulse_event('{frame_align_err: 1'b1, default: 1'b0});
    wait_irq(1'b1);
    read_expect("irq_pending after error", addr_irq_pending, 32'h1);
    axi_write(addr_irq_pending, 32'h1);
    wait_irq(1'b0);
    read_expect("irq_pending after clear", addr_irq_pending, '0);
    axi_write(addr_link_disable, 32'h1);
    // The SYSREF edge shows when the pulse has crossed into s_axi_aclk.
    pulse_event('{frame_align_err: 1'b1, sysref_edge: 1'b1, default: 1'b0});
    wait_for_bits(addr_sysref_status, 32'h1, "SYSREF status bit 0");
    read_expect("irq_pending with link disabled", addr_irq_pending, '0);
    check_word("irq with link disabled", reg_data_t'(irq), '0);
    axi_write(addr_sysref_status, 32'h1);
    read_expect("SYSREF status after clear", addr_sysref_status, '0);
  endtask

  task automatic check_sysref_status();
    pulse_event('{sysref_edge: 1'b1, default: 1'b0});
    wait_for_bits(addr_sysref_status, 32'h1, "SYSREF edge status");
    read_expect("SYSREF status after edge", addr_sysref_status, 32'h1);
    pulse_event('{sysref_align_err: 1'b1, default: 1'b0});
    wait_for_bits(addr_sysref_status, 32'h2, "SYSREF alignment error status");
    read_expect("SYSREF status after both", addr_sysref_status, 32'h3);
    axi_write(addr_sysref_status, 32'h1);
    read_expect("SYSREF status after clearing bit 0", addr_sysref_status, 32'h2);
    axi_write(addr_sysref_status, 32'h2);
    read_expect("SYSREF status after clearing bit 1", addr_sysref_status, '0);
  endtask

  task automatic check_lanes();
    reg_data_t ilas_exp [num_lanes][4];
    reg_addr_t lane_addr;
    for (int w = 0; w < 4; w++) begin
      for (int l = 0; l < num_lanes; l++) begin
        ilas_exp[l][w] = $urandom;
        ilas_lanes[l] = '{valid: 1'b1, addr: 2'(w), data: ilas_exp[l][w]};
      end
      @(posedge s_axi_aclk);
      #2;
    end
    ilas_lanes = '0;
    for (int l = 0; l < num_lanes; l++) lane_status[l] = lane_status_t'($urandom);
    ctrl_state = 2'b10;
    read_expect("ctrl_state", addr_ctrl_state, 32'h2);
    for (int l = 0; l < num_lanes; l++) begin
      lane_addr = addr_lane_base + reg_addr_t'(l * lane_stride);
      read_expect($sformatf("lane %0d status", l), lane_addr, lane_status_word(lane_status[l]));
      read_expect($sformatf("lane %0d error count", l), lane_addr + 12'h002,
                  reg_data_t'(lane_status[l].frame_align_err_cnt));
      for (int w = 0; w < 4; w++) begin
        read_expect($sformatf("lane %0d ILAS word %0d", l, w),
                    lane_addr + reg_addr_t'(16 + w), ilas_exp[l][w]);
      end
    end
  endtask

  initial begin
    seed_value = $urandom(rand_seed);
    rst_n = 1'b0;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr = '0;
    s_axi_wvalid = 1'b0;
    s_axi_wdata = '0;
    s_axi_bready = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr = '0;
    s_axi_rready = 1'b0;
    core_events = '0;
    ctrl_state = '0;
    lane_status = '0;
    ilas_lanes = '0;
    repeat (16) @(posedge s_axi_aclk);
    #2;
    rst_n = 1'b1;
    @(posedge s_axi_aclk);
    #2;
    if (!timed_out) check_reset_values();
    if (!timed_out) check_scratch();
    if (!timed_out) check_write_protect();
    if (!timed_out) check_interrupts();
    if (!timed_out) check_sysref_status();
    if (!timed_out) check_lanes();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
